//--- dv/cam_stim.txt
# cmd fields: W addr data | R addr expected | T | E level | G
# addr, data and expected in hex, level is 0 or 1
G
E 1
W 000 00123456
W 004 00340102
W 008 40000005
W 00c 0056beef
W 010 4000000c
W 014 0078cafe
W 018 00790001
W 01c 80000000
R 000 00123456
R 014 0078cafe
R 104 00000001
R 100 00000000
W 104 00000007
R 208 00000000
W 3f0 00000001
G
R 104 00000005
W 010 40000003
G
E 0
T
G
E 1
G

//--- files.f
logic/cam_pkg.sv
logic/clock_reset.sv
logic/axil_cfg_slave.sv
logic/sensor_init_seq.sv
logic/cfg_bus_arbiter.sv
logic/cfg_table_ram.sv
logic/cam_ctrl_top.sv
dv/tb_cam_ctrl.sv

//--- Bender.yml
package:
  name: cam_ctrl

sources:
  - logic/cam_pkg.sv
  - logic/clock_reset.sv
  - logic/axil_cfg_slave.sv
  - logic/sensor_init_seq.sv
  - logic/cfg_bus_arbiter.sv
  - logic/cfg_table_ram.sv
  - logic/cam_ctrl_top.sv
  - target: test
    files:
      - dv/tb_cam_ctrl.sv

//--- dv/tb_cam_ctrl.sv
module tb_cam_ctrl;

	localparam int HOLD_EDGES = 32;		// 2^(RST_CNT_W-1) with RST_CNT_W = 6
	localparam int TIMEOUT    = 200;	// cycles per handshake wait
	localparam int POLL_LIMIT = 100;	// status polls per sequence

	logic        clk_osc_bufg = 1'b0;
	logic        i_reset_sensor;
	logic        i_stream_enable;
	logic        i_cfg_ready;
	logic        i_s_axil_awvalid;
	logic        o_s_axil_awready;
	logic [11:0] i_s_axil_awaddr;
	logic        i_s_axil_wvalid;
	logic        o_s_axil_wready;
	logic [31:0] i_s_axil_wdata;
	logic        o_s_axil_bvalid;
	logic        i_s_axil_bready;
	logic [1:0]  o_s_axil_bresp;
	logic        i_s_axil_arvalid;
	logic        o_s_axil_arready;
	logic [11:0] i_s_axil_araddr;
	logic        o_s_axil_rvalid;
	logic        i_s_axil_rready;
	logic [31:0] o_s_axil_rdata;
	logic [1:0]  o_s_axil_rresp;
	logic        o_reset_sensor_n;
	logic        o_sensor_reset_done;
	logic        o_stream_reset;
	logic        o_cfg_valid;
	logic [7:0]  o_cfg_reg;
	logic [15:0] o_cfg_val;

	// ------------------------------
	// reference model state
	// ------------------------------
	logic [31:0] tbl [64];		// table as the host wrote it
	logic [55:0] exp_q [$];		// {min gap, reg, val} per expected write
	logic [55:0] head;
	int          hold;			// edges since reset release, saturates
	logic        sync0;
	logic        sync1;			// expected stream reset
	logic        stream_req;
	logic        model_valid = 1'b0;
	logic        stall = 1'b0;	// valid without ready last cycle
	logic [7:0]  stall_reg;
	logic [15:0] stall_val;
	int          cycle_cnt = 0;
	int          last_xfer = 0;
	logic [31:0] rnd_state = 32'hf8ec07fe;

	cam_ctrl_top #(.RST_CNT_W(6)) dut (
		.clk_osc_bufg, .i_reset_sensor, .i_stream_enable, .i_cfg_ready,
		.i_s_axil_awvalid, .o_s_axil_awready, .i_s_axil_awaddr,
		.i_s_axil_wvalid, .o_s_axil_wready, .i_s_axil_wdata,
		.o_s_axil_bvalid, .i_s_axil_bready, .o_s_axil_bresp,
		.i_s_axil_arvalid, .o_s_axil_arready, .i_s_axil_araddr,
		.o_s_axil_rvalid, .i_s_axil_rready, .o_s_axil_rdata, .o_s_axil_rresp,
		.o_reset_sensor_n, .o_sensor_reset_done, .o_stream_reset,
		.o_cfg_valid, .o_cfg_reg, .o_cfg_val
	);

	always #10 clk_osc_bufg = ~clk_osc_bufg;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// sensor side back-pressure, ready about 3 cycles in 4
	always @(posedge clk_osc_bufg) begin
		#1;
		rnd_state = xorshift32(rnd_state);
		i_cfg_ready = rnd_state[0] | rnd_state[3];
	end

	task automatic step();
		@(posedge clk_osc_bufg);
		#1;
	endtask

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
		end
	endtask

	// ------------------------------
	// output monitor, mid cycle
	// ------------------------------
	always @(negedge clk_osc_bufg) begin
		cycle_cnt = cycle_cnt + 1;
		if (model_valid) begin
			check("o_reset_sensor_n", o_reset_sensor_n, hold == HOLD_EDGES);
			check("o_sensor_reset_done", o_sensor_reset_done, hold == HOLD_EDGES);
			check("o_stream_reset", o_stream_reset, sync1);
			if (stall) begin	// payload frozen while stalled
				check("o_cfg_valid", o_cfg_valid, 1);
				check("o_cfg_reg", o_cfg_reg, stall_reg);
				check("o_cfg_val", o_cfg_val, stall_val);
			end
			if (o_cfg_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					fail_now("config write presented while none was expected");
				end
				head = exp_q[0];
				check("o_cfg_reg", o_cfg_reg, head[23:16]);
				check("o_cfg_val", o_cfg_val, head[15:0]);
				if (i_cfg_ready) begin	// next edge is the transfer
					if (cycle_cnt - last_xfer <= head[55:24]) begin
						fail_now("config write came inside an OP_WAIT window");
					end
					last_xfer = cycle_cnt;
					head = exp_q.pop_front();
				end
			end else begin
				check("o_cfg_valid", o_cfg_valid, 0);
			end
			stall     = o_cfg_valid && !i_cfg_ready;
			stall_reg = o_cfg_reg;
			stall_val = o_cfg_val;
		end
		// advance to the state after the coming edge
		stream_req = !i_stream_enable || hold != HOLD_EDGES;
		if (i_reset_sensor) begin
			hold        = 0;
			sync0       = 1'b1;
			sync1       = 1'b1;
			stall       = 1'b0;
			model_valid = 1'b1;
		end else begin
			sync1 = sync0;
			sync0 = stream_req;
			if (hold < HOLD_EDGES) begin
				hold = hold + 1;
			end
		end
	end

	// ------------------------------
	// AXI4-Lite host
	// ------------------------------
	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int t;
		i_s_axil_awaddr  = addr;
		i_s_axil_wdata   = data;
		i_s_axil_awvalid = 1'b1;
		i_s_axil_wvalid  = 1'b1;
		t = 0;
		while (!o_s_axil_awready) begin
			step();
			t++;
			if (t > TIMEOUT) fail_now("write address and data were never accepted");
		end
		check("o_s_axil_wready", o_s_axil_wready, 1);	// aw and w go together
		step();	// acceptance edge
		i_s_axil_awvalid = 1'b0;
		i_s_axil_wvalid  = 1'b0;
		t = 0;
		while (!o_s_axil_bvalid) begin
			step();
			t++;
			if (t > TIMEOUT) fail_now("write response never arrived");
		end
		resp = o_s_axil_bresp;
		step();	// bvalid held one cycle without ready first
		check("o_s_axil_bvalid", o_s_axil_bvalid, 1);
		check("o_s_axil_bresp", o_s_axil_bresp, resp);
		i_s_axil_bready = 1'b1;
		step();
		i_s_axil_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int t;
		i_s_axil_araddr  = addr;
		i_s_axil_arvalid = 1'b1;
		t = 0;
		while (!o_s_axil_arready) begin
			step();
			t++;
			if (t > TIMEOUT) fail_now("read address was never accepted");
		end
		step();
		i_s_axil_arvalid = 1'b0;
		t = 0;
		while (!o_s_axil_rvalid) begin
			step();
			t++;
			if (t > TIMEOUT) fail_now("read response never arrived");
		end
		data = o_s_axil_rdata;
		resp = o_s_axil_rresp;
		step();	// rvalid held one cycle without ready
		check("o_s_axil_rvalid", o_s_axil_rvalid, 1);
		check("o_s_axil_rdata", o_s_axil_rdata, data);
		check("o_s_axil_rresp", o_s_axil_rresp, resp);
		i_s_axil_rready = 1'b1;
		step();
		i_s_axil_rready = 1'b0;
	endtask

	task automatic host_write(input logic [11:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		logic [1:0] exp_resp;
		if (addr < cam_pkg::ADDR_CTRL) begin
			tbl[addr[7:2]] = data;
			exp_resp = cam_pkg::RESP_OKAY;
		end else if (addr == cam_pkg::ADDR_CTRL) begin
			exp_resp = cam_pkg::RESP_OKAY;
		end else begin
			exp_resp = cam_pkg::RESP_SLVERR;	// status is read only
		end
		axi_write(addr, data, resp);
		check("o_s_axil_bresp", resp, exp_resp);
	endtask

	task automatic host_read(input logic [11:0] addr, input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0]  resp;
		logic [1:0]  exp_resp;
		if (addr <= cam_pkg::ADDR_CTRL || addr == cam_pkg::ADDR_STATUS) begin
			exp_resp = cam_pkg::RESP_OKAY;
		end else begin
			exp_resp = cam_pkg::RESP_SLVERR;
		end
		axi_read(addr, data, resp);
		check("o_s_axil_rresp", resp, exp_resp);
		check("o_s_axil_rdata", data, exp);
	endtask

	task automatic pulse_reset();
		i_reset_sensor = 1'b1;
		repeat (2) @(posedge clk_osc_bufg);
		#1;
		i_reset_sensor = 1'b0;
	endtask

	task automatic set_stream(input int level);
		i_stream_enable = level[0];
		repeat (4) step();	// synchroniser delay, monitor checks it
	endtask

	// ------------------------------
	// sequence start and playback
	// ------------------------------
	task automatic run_sequence();
		logic [31:0] data;
		logic [31:0] gap;
		logic [1:0]  resp;
		int          i;
		int          t;
		bit          stop;
		if (hold != HOLD_EDGES) begin
			// sensor still held, start gets dropped
			axi_write(cam_pkg::ADDR_CTRL, 32'h1, resp);
			check("o_s_axil_bresp", resp, cam_pkg::RESP_OKAY);
			t = 0;
			while (!o_sensor_reset_done) begin
				step();
				t++;
				if (t > TIMEOUT) fail_now("sensor reset was never released");
			end
			axi_read(cam_pkg::ADDR_STATUS, data, resp);
			check("o_s_axil_rdata", data, 32'h1);
		end else begin
			gap  = 0;
			stop = 0;
			for (i = 0; i < 64 && !stop; i++) begin
				case (tbl[i][31:30])
					2'd0: begin
						exp_q.push_back({gap, tbl[i][23:16], tbl[i][15:0]});
						gap = 0;
					end
					2'd1: gap = gap + tbl[i][15:0];	// wait count
					default: stop = 1;
				endcase
			end
			axi_write(cam_pkg::ADDR_CTRL, 32'h1, resp);
			check("o_s_axil_bresp", resp, cam_pkg::RESP_OKAY);
			for (i = 0; i < 8; i++) begin	// host fetches race the sequencer
				axi_read(12'(i * 4), data, resp);
				check("o_s_axil_rresp", resp, cam_pkg::RESP_OKAY);
				check("o_s_axil_rdata", data, tbl[i]);
			end
			t    = 0;
			data = 0;
			while (!data[2]) begin
				axi_read(cam_pkg::ADDR_STATUS, data, resp);
				t++;
				if (t > POLL_LIMIT) fail_now("sequence never reported done");
			end
			check("o_s_axil_rdata", data, 32'h5);	// reset done, idle, done
			if (exp_q.size() != 0) begin
				fail_now("sequence reported done with config writes still missing");
			end
		end
	endtask

	initial begin
		int              fd;
		int              code;
		int              level;
		logic [8*8-1:0]  cmd;
		logic [8*128-1:0] line;
		logic [11:0]     addr;
		logic [31:0]     data;
		i_reset_sensor   = 1'b1;
		i_stream_enable  = 1'b0;
		i_cfg_ready      = 1'b0;
		i_s_axil_awvalid = 1'b0;
		i_s_axil_awaddr  = '0;
		i_s_axil_wvalid  = 1'b0;
		i_s_axil_wdata   = '0;
		i_s_axil_bready  = 1'b0;
		i_s_axil_arvalid = 1'b0;
		i_s_axil_araddr  = '0;
		i_s_axil_rready  = 1'b0;
		repeat (2) @(posedge clk_osc_bufg);
		#1;
		i_reset_sensor = 1'b0;
		fd = $fopen("dv/cam_stim.txt", "r");
		if (fd == 0) fail_now("could not open dv/cam_stim.txt");
		while ($fscanf(fd, "%s", cmd) == 1) begin
			if (cmd == "#") begin
				code = $fgets(line, fd);
			end else if (cmd == "W") begin
				code = $fscanf(fd, "%h %h", addr, data);
				if (code != 2) fail_now("W line in stim file lacks address or data");
				host_write(addr, data);
			end else if (cmd == "R") begin
				code = $fscanf(fd, "%h %h", addr, data);
				if (code != 2) fail_now("R line in stim file lacks address or expected value");
				host_read(addr, data);
			end else if (cmd == "T") begin
				pulse_reset();
			end else if (cmd == "E") begin
				code = $fscanf(fd, "%d", level);
				if (code != 1) fail_now("E line in stim file lacks a level");
				set_stream(level);
			end else if (cmd == "G") begin
				run_sequence();
			end else begin
				fail_now("unknown command in stim file");
			end
		end
		$fclose(fd);
		repeat (5) step();
		if (exp_q.size() != 0) begin
			fail_now("config writes still expected at the end of the run");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

//--- logic/cam_ctrl_top.sv
module cam_ctrl_top #(
	parameter int RST_CNT_W = 17
) (
	input  logic        clk_osc_bufg,
	input  logic        i_reset_sensor,
	input  logic        i_stream_enable,
	input  logic        i_cfg_ready,
	// axi4-lite slave
	input  logic        i_s_axil_awvalid,
	output logic        o_s_axil_awready,
	input  logic [11:0] i_s_axil_awaddr,
	input  logic        i_s_axil_wvalid,
	output logic        o_s_axil_wready,
	input  logic [31:0] i_s_axil_wdata,
	output logic        o_s_axil_bvalid,
	input  logic        i_s_axil_bready,
	output logic [1:0]  o_s_axil_bresp,
	input  logic        i_s_axil_arvalid,
	output logic        o_s_axil_arready,
	input  logic [11:0] i_s_axil_araddr,
	output logic        o_s_axil_rvalid,
	input  logic        i_s_axil_rready,
	output logic [31:0] o_s_axil_rdata,
	output logic [1:0]  o_s_axil_rresp,
	// sensor side
	output logic        o_reset_sensor_n,
	output logic        o_sensor_reset_done,
	output logic        o_stream_reset,
	output logic        o_cfg_valid,
	output logic [7:0]  o_cfg_reg,
	output logic [15:0] o_cfg_val
);

	logic seq_start;
	logic seq_busy;
	logic seq_done;

	// ------------------------------
	// memory bus wires
	// ------------------------------
	logic                         m0_req, m0_we, m0_gnt, m0_rvalid;
	logic [cam_pkg::TABLE_AW-1:0] m0_addr;
	logic [31:0]                  m0_wdata, m0_rdata;
	logic                         m1_req, m1_gnt, m1_rvalid;
	logic [cam_pkg::TABLE_AW-1:0] m1_addr;
	logic [31:0]                  m1_rdata;
	logic                         ram_en, ram_we;
	logic [cam_pkg::TABLE_AW-1:0] ram_addr;
	logic [31:0]                  ram_wdata, ram_rdata;

	clock_reset #(.RST_CNT_W(RST_CNT_W)) u_clock_reset (
		.clk_osc_bufg, .i_reset_sensor, .i_stream_enable,
		.o_reset_sensor_n, .o_sensor_reset_done, .o_stream_reset
	);

	axil_cfg_slave u_axil_cfg_slave (
		.clk_osc_bufg, .i_reset_sensor,
		.i_s_axil_awvalid, .o_s_axil_awready, .i_s_axil_awaddr,
		.i_s_axil_wvalid, .o_s_axil_wready, .i_s_axil_wdata,
		.o_s_axil_bvalid, .i_s_axil_bready, .o_s_axil_bresp,
		.i_s_axil_arvalid, .o_s_axil_arready, .i_s_axil_araddr,
		.o_s_axil_rvalid, .i_s_axil_rready, .o_s_axil_rdata, .o_s_axil_rresp,
		.i_sensor_reset_done(o_sensor_reset_done),
		.i_seq_busy(seq_busy), .i_seq_done(seq_done), .o_seq_start(seq_start),
		.o_mem_req(m0_req), .o_mem_we(m0_we), .o_mem_addr(m0_addr),
		.o_mem_wdata(m0_wdata), .i_mem_gnt(m0_gnt),
		.i_mem_rvalid(m0_rvalid), .i_mem_rdata(m0_rdata)
	);

	sensor_init_seq u_sensor_init_seq (
		.clk_osc_bufg, .i_reset_sensor,
		.i_start(seq_start), .i_sensor_reset_done(o_sensor_reset_done),
		.o_busy(seq_busy), .o_done(seq_done),
		.o_mem_req(m1_req), .o_mem_addr(m1_addr), .i_mem_gnt(m1_gnt),
		.i_mem_rvalid(m1_rvalid), .i_mem_rdata(m1_rdata),
		.o_cfg_valid, .i_cfg_ready, .o_cfg_reg, .o_cfg_val
	);

	cfg_bus_arbiter u_cfg_bus_arbiter (
		.clk_osc_bufg, .i_reset_sensor,
		.i_m0_req(m0_req), .i_m0_we(m0_we), .i_m0_addr(m0_addr), .i_m0_wdata(m0_wdata),
		.o_m0_gnt(m0_gnt), .o_m0_rvalid(m0_rvalid), .o_m0_rdata(m0_rdata),
		.i_m1_req(m1_req), .i_m1_addr(m1_addr),
		.o_m1_gnt(m1_gnt), .o_m1_rvalid(m1_rvalid), .o_m1_rdata(m1_rdata),
		.o_ram_en(ram_en), .o_ram_we(ram_we), .o_ram_addr(ram_addr),
		.o_ram_wdata(ram_wdata), .i_ram_rdata(ram_rdata)
	);

	cfg_table_ram u_cfg_table_ram (
		.clk_osc_bufg,
		.i_en(ram_en), .i_we(ram_we), .i_addr(ram_addr),
		.i_wdata(ram_wdata), .o_rdata(ram_rdata)
	);

endmodule

//--- logic/cfg_table_ram.sv
module cfg_table_ram (
	input  logic                          clk_osc_bufg,
	input  logic                          i_en,
	input  logic                          i_we,
	input  logic [cam_pkg::TABLE_AW-1:0]  i_addr,
	input  logic [31:0]                   i_wdata,
	output logic [31:0]                   o_rdata
);

	// ------------------------------
	// 64 x 32 table storage
	// ------------------------------
	logic [31:0] mem [cam_pkg::TABLE_DEPTH];	// contents undefined until written

	always_ff @(posedge clk_osc_bufg) begin
		if (i_en) begin
			if (i_we) begin
				mem[i_addr] <= i_wdata;
			end
			o_rdata <= mem[i_addr];	// registered read, old data on write
		end
	end

endmodule

//--- logic/cfg_bus_arbiter.sv
module cfg_bus_arbiter (
	input  logic        clk_osc_bufg,
	input  logic        i_reset_sensor,
	// master 0, host slave
	input  logic        i_m0_req,
	input  logic        i_m0_we,
	input  logic [5:0]  i_m0_addr,
	input  logic [31:0] i_m0_wdata,
	output logic        o_m0_gnt,
	output logic        o_m0_rvalid,
	output logic [31:0] o_m0_rdata,
	// master 1, sequencer
	input  logic        i_m1_req,
	input  logic [5:0]  i_m1_addr,
	output logic        o_m1_gnt,
	output logic        o_m1_rvalid,
	output logic [31:0] o_m1_rdata,
	// ram side
	output logic        o_ram_en,
	output logic        o_ram_we,
	output logic [5:0]  o_ram_addr,
	output logic [31:0] o_ram_wdata,
	input  logic [31:0] i_ram_rdata
);

	logic last_m1;	// master 1 had the last grant
	logic owner_m1;	// who gets the read strobe
	logic rd_pend;	// grant last cycle

	// ------------------------------
	// round-robin grant
	// ------------------------------
	assign o_m0_gnt = i_m0_req && (!i_m1_req || last_m1);
	assign o_m1_gnt = i_m1_req && (!i_m0_req || !last_m1);

	assign o_ram_en    = o_m0_gnt || o_m1_gnt;
	assign o_ram_we    = o_m0_gnt && i_m0_we;	// sequencer never writes
	assign o_ram_addr  = o_m1_gnt ? i_m1_addr : i_m0_addr;
	assign o_ram_wdata = i_m0_wdata;

	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset_sensor) begin
			last_m1  <= 1'b1;	// host first on a tie
			owner_m1 <= 1'b0;
			rd_pend  <= 1'b0;
		end else begin
			rd_pend <= o_ram_en;
			if (o_ram_en) begin
				last_m1  <= o_m1_gnt;
				owner_m1 <= o_m1_gnt;
			end
		end
	end

	// read data one cycle after grant, steered to the owner
	assign o_m0_rvalid = rd_pend && !owner_m1;
	assign o_m1_rvalid = rd_pend && owner_m1;
	assign o_m0_rdata  = i_ram_rdata;
	assign o_m1_rdata  = i_ram_rdata;

	a_one_gnt: assert property (@(posedge clk_osc_bufg) disable iff (i_reset_sensor)
		!(o_m0_gnt && o_m1_gnt));

endmodule

//--- logic/sensor_init_seq.sv
module sensor_init_seq (
	input  logic        clk_osc_bufg,
	input  logic        i_reset_sensor,
	// control
	input  logic        i_start,
	input  logic        i_sensor_reset_done,
	output logic        o_busy,
	output logic        o_done,
	// config memory master 1, read only
	output logic        o_mem_req,
	output logic [5:0]  o_mem_addr,
	input  logic        i_mem_gnt,
	input  logic        i_mem_rvalid,
	input  logic [31:0] i_mem_rdata,
	// sensor config port
	output logic        o_cfg_valid,
	input  logic        i_cfg_ready,
	output logic [7:0]  o_cfg_reg,
	output logic [15:0] o_cfg_val
);

	cam_pkg::seq_state_e state;
	cam_pkg::seq_op_e    entry_op;

	logic [cam_pkg::TABLE_AW-1:0] entry_idx;
	logic [15:0]                  wait_cnt;	// OP_WAIT countdown
	logic                         last_entry;

	assign entry_op   = cam_pkg::seq_op_e'(i_mem_rdata[cam_pkg::OP_MSB:cam_pkg::OP_LSB]);
	assign last_entry = entry_idx == cam_pkg::TABLE_AW'(cam_pkg::TABLE_DEPTH - 1);

	assign o_busy     = (state != cam_pkg::SEQ_IDLE) && (state != cam_pkg::SEQ_DONE);
	assign o_mem_req  = state == cam_pkg::SEQ_FETCH;	// drops in the cycle after gnt
	assign o_mem_addr = entry_idx;

	// ------------------------------
	// table playback FSM
	// ------------------------------
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset_sensor) begin
			state       <= cam_pkg::SEQ_IDLE;
			entry_idx   <= '0;
			o_cfg_valid <= 1'b0;
			o_done      <= 1'b0;
		end else begin
			case (state)
				cam_pkg::SEQ_IDLE, cam_pkg::SEQ_DONE: begin
					if (i_start && i_sensor_reset_done) begin	// ignored while sensor held
						entry_idx <= '0;
						o_done    <= 1'b0;
						state     <= cam_pkg::SEQ_FETCH;
					end
				end
				cam_pkg::SEQ_FETCH: begin
					if (i_mem_gnt) begin
						state <= cam_pkg::SEQ_WAIT_RD;
					end
				end
				cam_pkg::SEQ_WAIT_RD: begin
					if (i_mem_rvalid) begin
						case (entry_op)
							cam_pkg::OP_WRITE: begin
								o_cfg_valid <= 1'b1;
								o_cfg_reg   <= i_mem_rdata[cam_pkg::REG_MSB:cam_pkg::REG_LSB];
								o_cfg_val   <= i_mem_rdata[cam_pkg::VAL_MSB:cam_pkg::VAL_LSB];
								state       <= cam_pkg::SEQ_ISSUE;
							end
							cam_pkg::OP_WAIT: begin
								wait_cnt <= i_mem_rdata[cam_pkg::VAL_MSB:cam_pkg::VAL_LSB];
								state    <= cam_pkg::SEQ_DELAY;
							end
							default: begin	// end marker, 2 or 3
								o_done <= 1'b1;
								state  <= cam_pkg::SEQ_DONE;
							end
						endcase
					end
				end
				cam_pkg::SEQ_ISSUE: begin
					if (i_cfg_ready) begin	// transfer cycle
						o_cfg_valid <= 1'b0;
						o_done      <= last_entry;
						entry_idx   <= entry_idx + 1'b1;
						state       <= last_entry ? cam_pkg::SEQ_DONE : cam_pkg::SEQ_FETCH;
					end
				end
				default: begin	// SEQ_DELAY
					if (wait_cnt == '0) begin
						o_done    <= last_entry;
						entry_idx <= entry_idx + 1'b1;
						state     <= last_entry ? cam_pkg::SEQ_DONE : cam_pkg::SEQ_FETCH;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
			endcase
		end
	end

	// payload frozen under back-pressure
	a_cfg_stable: assert property (@(posedge clk_osc_bufg) disable iff (i_reset_sensor)
		o_cfg_valid && !i_cfg_ready |=>
		o_cfg_valid && $stable(o_cfg_reg) && $stable(o_cfg_val));

endmodule

//--- logic/axil_cfg_slave.sv
module axil_cfg_slave (
	input  logic        clk_osc_bufg,
	input  logic        i_reset_sensor,
	// axi4-lite slave
	input  logic        i_s_axil_awvalid,
	output logic        o_s_axil_awready,
	input  logic [11:0] i_s_axil_awaddr,
	input  logic        i_s_axil_wvalid,
	output logic        o_s_axil_wready,
	input  logic [31:0] i_s_axil_wdata,
	output logic        o_s_axil_bvalid,
	input  logic        i_s_axil_bready,
	output logic [1:0]  o_s_axil_bresp,
	input  logic        i_s_axil_arvalid,
	output logic        o_s_axil_arready,
	input  logic [11:0] i_s_axil_araddr,
	output logic        o_s_axil_rvalid,
	input  logic        i_s_axil_rready,
	output logic [31:0] o_s_axil_rdata,
	output logic [1:0]  o_s_axil_rresp,
	// status and control
	input  logic        i_sensor_reset_done,
	input  logic        i_seq_busy,
	input  logic        i_seq_done,
	output logic        o_seq_start,
	// config memory master 0
	output logic        o_mem_req,
	output logic        o_mem_we,
	output logic [5:0]  o_mem_addr,
	output logic [31:0] o_mem_wdata,
	input  logic        i_mem_gnt,
	input  logic        i_mem_rvalid,
	input  logic [31:0] i_mem_rdata
);

	cam_pkg::axil_state_e state;

	logic wr_table;	// write hits table window
	logic rd_table;
	logic wr_ctrl;

	// table window is everything below ctrl
	assign wr_table = i_s_axil_awaddr < cam_pkg::ADDR_CTRL;
	assign rd_table = i_s_axil_araddr < cam_pkg::ADDR_CTRL;
	assign wr_ctrl  = i_s_axil_awaddr == cam_pkg::ADDR_CTRL;

	// ------------------------------
	// one transaction at a time
	// ------------------------------
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset_sensor) begin
			state            <= cam_pkg::AX_IDLE;
			o_s_axil_awready <= 1'b0;
			o_s_axil_wready  <= 1'b0;
			o_s_axil_arready <= 1'b0;
			o_s_axil_bvalid  <= 1'b0;
			o_s_axil_rvalid  <= 1'b0;
			o_mem_req        <= 1'b0;
			o_seq_start      <= 1'b0;
		end else begin
			o_seq_start <= 1'b0;	// single cycle pulse
			case (state)
				cam_pkg::AX_IDLE: begin
					if (o_s_axil_awready) begin	// aw and w taken this edge
						o_s_axil_awready <= 1'b0;
						o_s_axil_wready  <= 1'b0;
						o_mem_addr       <= i_s_axil_awaddr[cam_pkg::TABLE_AW+1:2];
						o_mem_wdata      <= i_s_axil_wdata;
						o_mem_we         <= 1'b1;
						if (wr_table) begin
							o_mem_req <= 1'b1;
							state     <= cam_pkg::AX_MEM;
						end else begin
							o_s_axil_bvalid <= 1'b1;
							o_s_axil_bresp  <= wr_ctrl ? cam_pkg::RESP_OKAY
								: cam_pkg::RESP_SLVERR;	// status or unmapped
							o_seq_start     <= wr_ctrl && i_s_axil_wdata[0];
							state           <= cam_pkg::AX_WRESP;
						end
					end else if (o_s_axil_arready) begin
						o_s_axil_arready <= 1'b0;
						o_mem_addr       <= i_s_axil_araddr[cam_pkg::TABLE_AW+1:2];
						o_mem_we         <= 1'b0;
						o_s_axil_rdata   <= '0;	// ctrl reads zero
						o_s_axil_rresp   <= cam_pkg::RESP_OKAY;
						if (rd_table) begin
							o_mem_req <= 1'b1;
							state     <= cam_pkg::AX_MEM;
						end else begin
							if (i_s_axil_araddr == cam_pkg::ADDR_STATUS) begin
								o_s_axil_rdata[cam_pkg::ST_RESET_DONE] <= i_sensor_reset_done;
								o_s_axil_rdata[cam_pkg::ST_SEQ_BUSY]   <= i_seq_busy;
								o_s_axil_rdata[cam_pkg::ST_SEQ_DONE]   <= i_seq_done;
							end else if (i_s_axil_araddr != cam_pkg::ADDR_CTRL) begin
								o_s_axil_rresp <= cam_pkg::RESP_SLVERR;
							end
							o_s_axil_rvalid <= 1'b1;
							state           <= cam_pkg::AX_RRESP;
						end
					end else if (i_s_axil_awvalid && i_s_axil_wvalid) begin
						o_s_axil_awready <= 1'b1;	// write wins over read
						o_s_axil_wready  <= 1'b1;
					end else if (i_s_axil_arvalid) begin
						o_s_axil_arready <= 1'b1;
					end
				end
				cam_pkg::AX_MEM: begin
					if (i_mem_gnt) begin
						o_mem_req <= 1'b0;
					end
					if (i_mem_rvalid) begin	// access done in ram
						if (o_mem_we) begin
							o_s_axil_bvalid <= 1'b1;
							o_s_axil_bresp  <= cam_pkg::RESP_OKAY;
							state           <= cam_pkg::AX_WRESP;
						end else begin
							o_s_axil_rvalid <= 1'b1;
							o_s_axil_rdata  <= i_mem_rdata;
							state           <= cam_pkg::AX_RRESP;
						end
					end
				end
				cam_pkg::AX_WRESP: begin
					if (i_s_axil_bready) begin
						o_s_axil_bvalid <= 1'b0;
						state           <= cam_pkg::AX_IDLE;
					end
				end
				default: begin	// AX_RRESP
					if (i_s_axil_rready) begin
						o_s_axil_rvalid <= 1'b0;
						state           <= cam_pkg::AX_IDLE;
					end
				end
			endcase
		end
	end

	a_one_resp: assert property (@(posedge clk_osc_bufg) disable iff (i_reset_sensor)
		!(o_s_axil_bvalid && o_s_axil_rvalid));
	a_b_hold: assert property (@(posedge clk_osc_bufg) disable iff (i_reset_sensor)
		o_s_axil_bvalid && !i_s_axil_bready |=> o_s_axil_bvalid && $stable(o_s_axil_bresp));
	a_r_hold: assert property (@(posedge clk_osc_bufg) disable iff (i_reset_sensor)
		o_s_axil_rvalid && !i_s_axil_rready |=>
		o_s_axil_rvalid && $stable(o_s_axil_rdata) && $stable(o_s_axil_rresp));

endmodule

//--- logic/clock_reset.sv
module clock_reset #(
	parameter int RST_CNT_W = 17	// hold time is 2^(RST_CNT_W-1) cycles
) (
	input  logic clk_osc_bufg,
	input  logic i_reset_sensor,		// system reset, one or more cycles
	input  logic i_stream_enable,		// stream on from host side
	output logic o_reset_sensor_n,		// sensor reset pin, low active
	output logic o_sensor_reset_done,	// polled by firmware
	output logic o_stream_reset
);

	logic [RST_CNT_W-1:0] reset_cnt_sensor;
	logic                 cnt_top;			// saturated, reset released
	logic                 stream_rst_req;
	logic [1:0]           stream_rst_sync;	// [1] is the output stage

	assign cnt_top = reset_cnt_sensor[RST_CNT_W-1];

	// ------------------------------
	// sensor reset hold counter
	// ------------------------------
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset_sensor) begin
			reset_cnt_sensor <= '0;
		end else if (!cnt_top) begin
			reset_cnt_sensor <= reset_cnt_sensor + 1'b1;	// stops once top bit sets
		end
	end

	// top bit drives both the pin and the done flag
	assign o_reset_sensor_n    = cnt_top;
	assign o_sensor_reset_done = cnt_top;

	// ------------------------------
	// stream reset
	// ------------------------------
	// held while stream is off or sensor still in reset
	assign stream_rst_req = !i_stream_enable || !cnt_top;

	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset_sensor) begin
			stream_rst_sync <= 2'b11;	// come out of reset asserted
		end else begin
			stream_rst_sync <= {stream_rst_sync[0], stream_rst_req};
		end
	end

	assign o_stream_reset = stream_rst_sync[1];

	// counter frozen from release until the next system reset
	a_cnt_hold: assert property (@(posedge clk_osc_bufg) disable iff (i_reset_sensor)
		cnt_top |=> $stable(reset_cnt_sensor))
		else $error("sensor reset counter moved after done");

endmodule

//--- logic/cam_pkg.sv
package cam_pkg;

	// ------------------------------
	// config table geometry
	// ------------------------------
	localparam int TABLE_DEPTH = 64;	// entries
	localparam int TABLE_AW    = 6;		// word address width

	// byte address map, table window sits below ctrl
	localparam logic [11:0] ADDR_CTRL   = 12'h100;	// bit0 start, write one
	localparam logic [11:0] ADDR_STATUS = 12'h104;

	// status register bits
	localparam int ST_RESET_DONE = 0;
	localparam int ST_SEQ_BUSY   = 1;
	localparam int ST_SEQ_DONE   = 2;

	// ------------------------------
	// table entry layout
	// ------------------------------
	localparam int OP_MSB  = 31;
	localparam int OP_LSB  = 30;
	localparam int REG_MSB = 23;	// sensor register
	localparam int REG_LSB = 16;
	localparam int VAL_MSB = 15;	// value or wait count
	localparam int VAL_LSB = 0;

	typedef enum logic [1:0] {
		OP_WRITE = 2'd0,
		OP_WAIT  = 2'd1,
		OP_END   = 2'd2	// 3 decodes as end too
	} seq_op_e;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_FETCH,
		SEQ_WAIT_RD,
		SEQ_ISSUE,
		SEQ_DELAY,
		SEQ_DONE
	} seq_state_e;

	typedef enum logic [1:0] {
		AX_IDLE,
		AX_MEM,
		AX_WRESP,
		AX_RRESP
	} axil_state_e;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
